/* hw/rs_defines.svh */
`ifndef RS_DEFINES_SVH
`define RS_DEFINES_SVH

// bits per symbol
`define RS_SYM_WIDTH 8

// largest no_of_parity
`define RS_MAX_PARITY 16

// coefficients per polynomial memory
`define RS_POLY_DEPTH 32

// low byte of x^8+x^4+x^3+x^2+1
`define RS_GF_POLY 8'h1D

`endif

/* hw/gf_pkg.sv */
`include "rs_defines.svh"

package gf_pkg;

	// one field symbol
	typedef logic [`RS_SYM_WIDTH-1:0] gf_elem_t;

	// degree, coefficient address or count
	typedef logic [$clog2(`RS_POLY_DEPTH)-1:0] deg_t;

endpackage

/* hw/mea_pkg.sv */
package mea_pkg;

	// which working polynomial
	typedef enum logic [1:0] {
		poly_u = 2'd0,
		poly_q = 2'd1,
		poly_r = 2'd2,
		poly_l = 2'd3
	} poly_id_t;

	typedef enum logic [2:0] {
		st_idle,
		st_init,
		st_trim_r,
		st_trim_q,
		st_decide,
		st_update,
		st_done
	} mea_state_t;

endpackage

/* hw/gf_mult.sv */
`include "rs_defines.svh"

module gf_mult (
	input  gf_pkg::gf_elem_t a,
	input  gf_pkg::gf_elem_t b,
	output gf_pkg::gf_elem_t p
);
	import gf_pkg::*;

	always_comb
	begin
		gf_elem_t acc;
		gf_elem_t sh;
		acc = '0;
		sh = a;
		for (int i = 0; i < `RS_SYM_WIDTH; i++)
		begin
			if (b[i])
				acc = acc ^ sh; // add this partial product
			// multiply by x and fold back
			sh = {sh[`RS_SYM_WIDTH-2:0], 1'b0} ^ (sh[`RS_SYM_WIDTH-1] ? `RS_GF_POLY : '0);
		end
		p = acc;
	end

endmodule

/* hw/poly_ram.sv */
`include "rs_defines.svh"

module poly_ram (
	input  logic             clock,
	input  logic             wr_en,
	input  gf_pkg::deg_t     wr_addr,
	input  gf_pkg::gf_elem_t wr_data,
	input  gf_pkg::deg_t     rd_addr_a,
	input  gf_pkg::deg_t     rd_addr_b,
	output gf_pkg::gf_elem_t rd_data_a,
	output gf_pkg::gf_elem_t rd_data_b
);
	import gf_pkg::*;

	gf_elem_t mem [`RS_POLY_DEPTH];

	always_ff @(posedge clock)
	begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
		rd_data_a <= mem[rd_addr_a]; // old data on a same-address write
		rd_data_b <= mem[rd_addr_b]; // shifted operand
	end

endmodule

/* hw/poly_bank.sv */
module poly_bank (
	input  logic             clock,
	input  logic             core_owns,
	input  logic [3:0]       ld_wr_en,
	input  gf_pkg::deg_t     ld_wr_addr [4],
	input  gf_pkg::gf_elem_t ld_wr_data [4],
	input  logic [3:0]       core_wr_en,
	input  gf_pkg::deg_t     core_wr_addr,
	input  gf_pkg::gf_elem_t core_wr_data_r,
	input  gf_pkg::gf_elem_t core_wr_data_q,
	input  gf_pkg::gf_elem_t core_wr_data_l,
	input  gf_pkg::gf_elem_t core_wr_data_u,
	input  gf_pkg::deg_t     rd_addr_a [4],
	input  gf_pkg::deg_t     rd_addr_b [4],
	input  gf_pkg::deg_t     out_rd_addr,
	output gf_pkg::gf_elem_t rd_data_a [4],
	output gf_pkg::gf_elem_t rd_data_b [4]
);
	import gf_pkg::*;
	import mea_pkg::*;

	gf_elem_t core_data [4];

	assign core_data[poly_u] = core_wr_data_u;
	assign core_data[poly_q] = core_wr_data_q;
	assign core_data[poly_r] = core_wr_data_r;
	assign core_data[poly_l] = core_wr_data_l;

	for (genvar p = 0; p < 4; p++)
	begin : g_poly
		logic     wr_en;
		deg_t     wr_addr;
		gf_elem_t wr_data;
		deg_t     ra;
		// L and R are read back by the output stage when the core is off
		localparam bit out_port = (p == poly_r) || (p == poly_l);

		assign wr_en   = core_owns ? core_wr_en[p] : ld_wr_en[p];
		assign wr_addr = core_owns ? core_wr_addr : ld_wr_addr[p];
		assign wr_data = core_owns ? core_data[p] : ld_wr_data[p];
		assign ra      = (out_port && !core_owns) ? out_rd_addr : rd_addr_a[p];

		poly_ram u_ram (
			.clock     (clock),
			.wr_en     (wr_en),
			.wr_addr   (wr_addr),
			.wr_data   (wr_data),
			.rd_addr_a (ra),
			.rd_addr_b (rd_addr_b[p]),
			.rd_data_a (rd_data_a[p]),
			.rd_data_b (rd_data_b[p])
		);
	end

	// loader and core never share a cycle
	a_no_ld_write: assert property (@(posedge clock) core_owns |-> ld_wr_en == '0);

endmodule

/* hw/coef_loader.sv */
`include "rs_defines.svh"

module coef_loader (
	input  logic             clock,
	input  logic             reset,
	input  logic             syndr_wr,
	input  gf_pkg::deg_t     syndr_addr,
	input  gf_pkg::gf_elem_t syndr_coef,
	input  logic             erasure_wr,
	input  gf_pkg::deg_t     erasure_addr,
	input  gf_pkg::gf_elem_t erasure_coef,
	input  gf_pkg::deg_t     no_of_parity,
	input  gf_pkg::deg_t     no_of_erasures,
	input  logic             init,
	output logic             init_done,
	output logic [3:0]       wr_en,
	output gf_pkg::deg_t     wr_addr [4],
	output gf_pkg::gf_elem_t wr_data [4]
);
	import gf_pkg::*;
	import mea_pkg::*;

	logic sweeping;
	deg_t sweep_addr;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			sweeping <= 1'b0;
			sweep_addr <= '0;
			init_done <= 1'b0;
		end
		else
		begin
			init_done <= 1'b0;
			if (init)
			begin
				sweeping <= 1'b1;
				sweep_addr <= '0;
			end
			else if (sweeping)
			begin
				sweep_addr <= sweep_addr + 1'b1;
				if (sweep_addr == deg_t'(`RS_POLY_DEPTH - 1))
				begin
					sweeping <= 1'b0;
					init_done <= 1'b1; // last address written on this edge
				end
			end
		end
	end

	always_comb
	begin
		wr_en = '0;
		for (int p = 0; p < 4; p++)
		begin
			wr_addr[p] = sweep_addr;
			wr_data[p] = '0;
		end
		if (sweeping)
		begin
			wr_en[poly_r] = 1'b1;
			wr_data[poly_r] = gf_elem_t'(sweep_addr == no_of_parity); // x^parity
			wr_en[poly_l] = 1'b1;
			wr_en[poly_q] = sweep_addr >= no_of_parity; // keep the syndrome
			if (no_of_erasures == '0)
			begin
				wr_en[poly_u] = 1'b1;
				wr_data[poly_u] = gf_elem_t'(sweep_addr == '0); // U = 1
			end
			else
				wr_en[poly_u] = sweep_addr > no_of_erasures; // keep G(x)
		end
		else
		begin
			if (syndr_wr)
			begin
				wr_en[poly_q] = 1'b1;
				wr_addr[poly_q] = syndr_addr;
				wr_data[poly_q] = syndr_coef;
			end
			if (erasure_wr)
			begin
				wr_en[poly_u] = 1'b1;
				wr_addr[poly_u] = erasure_addr;
				wr_data[poly_u] = erasure_coef;
			end
		end
	end

endmodule

/* hw/mea_core.sv */
`include "rs_defines.svh"

module mea_core (
	input  logic                clock,
	input  logic                reset,
	input  logic                start,
	input  gf_pkg::deg_t        no_of_parity,
	input  gf_pkg::deg_t        no_of_erasures,
	output logic                busy,
	output logic                done,
	output gf_pkg::deg_t        locator_degree,
	output mea_pkg::mea_state_t state,
	output logic                core_owns,
	output logic                ld_init,
	input  logic                ld_init_done,
	input  gf_pkg::gf_elem_t    rd_data_a [4],
	input  gf_pkg::gf_elem_t    rd_data_b [4],
	output gf_pkg::deg_t        rd_addr_a [4],
	output gf_pkg::deg_t        rd_addr_b [4],
	output logic [3:0]          wr_en,
	output gf_pkg::deg_t        wr_addr,
	output gf_pkg::gf_elem_t    wr_data_r,
	output gf_pkg::gf_elem_t    wr_data_q,
	output gf_pkg::gf_elem_t    wr_data_l,
	output gf_pkg::gf_elem_t    wr_data_u
);
	import gf_pkg::*;
	import mea_pkg::*;

	localparam int CW = $clog2(`RS_POLY_DEPTH) + 1;

	deg_t deg_r, deg_q, deg_l, deg_u;
	deg_t shift, iter_cnt;
	gf_elem_t lead_r, lead_q, lead_a, lead_b;
	logic swap, trim_wait, step_r, step_q;
	logic [CW-1:0] pass_cnt, rd_j;
	logic rd_fire;
	deg_t rd_i;
	logic swap_now;
	deg_t diff, grow, keep;
	logic v1, neg1, v2;
	deg_t addr1;
	gf_elem_t x1, y1, x2, y2, p1, p2, p3, p4;

	assign busy = (state != st_idle) && (state != st_done);
	assign core_owns = busy && (state != st_init); // loader sweeps during init

	assign step_r = (state == st_trim_r) && !trim_wait && rd_data_a[poly_r] == '0 && deg_r != '0;
	assign step_q = (state == st_trim_q) && rd_data_a[poly_q] == '0 && deg_q != '0;

	// update pass walks from the top so shifted reads see old data
	assign rd_i = deg_t'(`RS_POLY_DEPTH - 1) - deg_t'(pass_cnt);
	assign rd_j = {1'b0, rd_i} - {1'b0, shift};
	assign rd_fire = (state == st_update) && (pass_cnt < CW'(`RS_POLY_DEPTH));

	always_comb
	begin
		for (int p = 0; p < 4; p++)
		begin
			rd_addr_a[p] = rd_i;
			rd_addr_b[p] = rd_j[CW-2:0];
		end
		if (state != st_update)
		begin
			// look ahead so trimming takes one cycle per coefficient
			rd_addr_a[poly_r] = step_r ? deg_r - 1'b1 : deg_r;
			rd_addr_a[poly_q] = step_q ? deg_q - 1'b1 : deg_q;
		end
	end

	// decide-state arithmetic
	assign swap_now = deg_r < deg_q;
	assign diff = swap_now ? deg_q - deg_r : deg_r - deg_q;
	assign grow = swap_now ? deg_l + diff : deg_u + diff;
	assign keep = swap_now ? deg_u : deg_l;

	assign lead_a = swap ? lead_r : lead_q; // lead of Q after swap
	assign lead_b = swap ? lead_q : lead_r; // lead of R after swap

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= st_idle;
			done <= 1'b0;
			ld_init <= 1'b0;
			locator_degree <= '0;
			trim_wait <= 1'b0;
			swap <= 1'b0;
			pass_cnt <= '0;
			iter_cnt <= '0;
		end
		else
		begin
			done <= 1'b0;
			ld_init <= 1'b0;
			case (state)
				st_idle, st_done:
					if (start)
					begin
						ld_init <= 1'b1;
						state <= st_init;
					end
				st_init:
					if (ld_init_done)
					begin
						deg_r <= no_of_parity;
						deg_q <= no_of_parity - 1'b1;
						deg_l <= '0;
						deg_u <= no_of_erasures; // 0 when U = 1
						iter_cnt <= '0;
						swap <= 1'b0;
						trim_wait <= 1'b1;
						state <= st_trim_r;
					end
				st_trim_r:
					if (trim_wait)
						trim_wait <= 1'b0; // first read in flight
					else if (step_r)
						deg_r <= deg_r - 1'b1;
					else
					begin
						lead_r <= rd_data_a[poly_r];
						state <= st_trim_q;
					end
				st_trim_q:
					if (step_q)
						deg_q <= deg_q - 1'b1;
					else
					begin
						lead_q <= rd_data_a[poly_q];
						state <= st_decide;
					end
				st_decide:
					if (deg_r < deg_l || iter_cnt == no_of_parity)
					begin
						locator_degree <= deg_l;
						done <= 1'b1;
						state <= st_done;
					end
					else
					begin
						swap <= swap_now;
						shift <= diff;
						deg_l <= (grow > keep) ? grow : keep;
						if (swap_now)
						begin
							deg_r <= deg_q;
							deg_q <= deg_r;
							deg_u <= deg_l;
						end
						iter_cnt <= iter_cnt + 1'b1;
						pass_cnt <= '0;
						state <= st_update;
					end
				st_update:
				begin
					pass_cnt <= pass_cnt + 1'b1;
					if (pass_cnt == CW'(`RS_POLY_DEPTH + 1))
					begin
						trim_wait <= 1'b1;
						state <= st_trim_r;
					end
				end
				default:
					state <= st_idle;
			endcase
		end
	end

	// stage 1 operands, memory data arrives here
	assign x1 = swap ? rd_data_a[poly_q] : rd_data_a[poly_r];
	assign y1 = neg1 ? '0 : (swap ? rd_data_b[poly_r] : rd_data_b[poly_q]);
	assign x2 = swap ? rd_data_a[poly_u] : rd_data_a[poly_l];
	assign y2 = neg1 ? '0 : (swap ? rd_data_b[poly_l] : rd_data_b[poly_u]);

	gf_mult u_mult_r_a (.a(lead_a), .b(x1), .p(p1));
	gf_mult u_mult_r_b (.a(lead_b), .b(y1), .p(p2));
	gf_mult u_mult_l_a (.a(lead_a), .b(x2), .p(p3));
	gf_mult u_mult_l_b (.a(lead_b), .b(y2), .p(p4));

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			v1 <= 1'b0;
			v2 <= 1'b0;
		end
		else
		begin
			v1 <= rd_fire;
			v2 <= v1;
		end
	end

	always_ff @(posedge clock)
	begin
		addr1 <= rd_i;
		neg1 <= rd_j[CW-1]; // below x^0 reads as zero
		wr_addr <= addr1;
		wr_data_r <= p1 ^ p2;
		wr_data_l <= p3 ^ p4;
		wr_data_q <= rd_data_a[poly_r]; // old R into Q on swap
		wr_data_u <= rd_data_a[poly_l];
	end

	always_comb
	begin
		wr_en = '0;
		wr_en[poly_r] = v2;
		wr_en[poly_l] = v2;
		wr_en[poly_q] = v2 && swap;
		wr_en[poly_u] = v2 && swap;
	end

	a_start_idle: assert property (@(posedge clock) disable iff (reset) busy |-> !start);
	a_shift_range: assert property (@(posedge clock) disable iff (reset)
		(state == st_update) |-> shift <= no_of_parity);

endmodule

/* hw/errata_out.sv */
`include "rs_defines.svh"

module errata_out (
	input  logic                clock,
	input  logic                reset,
	input  logic                start,
	input  mea_pkg::mea_state_t state,
	input  logic                send_coefs,
	output gf_pkg::deg_t        rd_addr,
	input  gf_pkg::gf_elem_t    rd_data_l,
	input  gf_pkg::gf_elem_t    rd_data_r,
	output logic                coef_valid,
	output gf_pkg::deg_t        coef_addr,
	output gf_pkg::gf_elem_t    loc_coef,
	output gf_pkg::gf_elem_t    mag_coef
);
	import gf_pkg::*;
	import mea_pkg::*;

	localparam int CW = $clog2(`RS_POLY_DEPTH) + 1;

	logic [CW-1:0] next_addr; // one past the end when finished
	logic fire, v1;
	deg_t a1;

	assign fire = (state == st_done) && send_coefs && !start &&
		(next_addr < CW'(`RS_POLY_DEPTH));
	assign rd_addr = deg_t'(next_addr);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			next_addr <= '0;
			v1 <= 1'b0;
			coef_valid <= 1'b0;
		end
		else
		begin
			if (start)
				next_addr <= '0; // new decode rewinds
			else if (fire)
				next_addr <= next_addr + 1'b1;
			v1 <= fire;
			coef_valid <= v1;
		end
	end

	always_ff @(posedge clock)
	begin
		a1 <= rd_addr;
		coef_addr <= a1;
		loc_coef <= rd_data_l;
		mag_coef <= rd_data_r;
	end

	// core leaves L and R alone while a read is in flight
	a_read_in_done: assert property (@(posedge clock) disable iff (reset)
		v1 |-> state == st_done);

endmodule

/* hw/errata_poly_gen.sv */
module errata_poly_gen (
	input  logic             clock,
	input  logic             reset,
	input  logic             syndr_wr,
	input  gf_pkg::deg_t     syndr_addr,
	input  gf_pkg::gf_elem_t syndr_coef,
	input  logic             erasure_wr,
	input  gf_pkg::deg_t     erasure_addr,
	input  gf_pkg::gf_elem_t erasure_coef,
	input  gf_pkg::deg_t     no_of_parity,
	input  gf_pkg::deg_t     no_of_erasures,
	input  logic             start,
	input  logic             send_coefs,
	output logic             busy,
	output logic             done,
	output gf_pkg::deg_t     locator_degree,
	output logic             coef_valid,
	output gf_pkg::deg_t     coef_addr,
	output gf_pkg::gf_elem_t loc_coef,
	output gf_pkg::gf_elem_t mag_coef
);
	import gf_pkg::*;
	import mea_pkg::*;

	logic ld_init, ld_init_done, core_owns;
	logic [3:0] ld_wr_en, core_wr_en;
	deg_t ld_wr_addr [4];
	gf_elem_t ld_wr_data [4];
	deg_t core_rd_addr_a [4], core_rd_addr_b [4];
	gf_elem_t rd_data_a [4], rd_data_b [4];
	deg_t core_wr_addr, out_rd_addr;
	gf_elem_t wr_data_r, wr_data_q, wr_data_l, wr_data_u;
	mea_state_t state;

	coef_loader u_loader (
		.clock (clock), .reset (reset),
		.syndr_wr (syndr_wr), .syndr_addr (syndr_addr), .syndr_coef (syndr_coef),
		.erasure_wr (erasure_wr), .erasure_addr (erasure_addr), .erasure_coef (erasure_coef),
		.no_of_parity (no_of_parity), .no_of_erasures (no_of_erasures),
		.init (ld_init), .init_done (ld_init_done),
		.wr_en (ld_wr_en), .wr_addr (ld_wr_addr), .wr_data (ld_wr_data)
	);

	poly_bank u_bank (
		.clock (clock), .core_owns (core_owns),
		.ld_wr_en (ld_wr_en), .ld_wr_addr (ld_wr_addr), .ld_wr_data (ld_wr_data),
		.core_wr_en (core_wr_en), .core_wr_addr (core_wr_addr),
		.core_wr_data_r (wr_data_r), .core_wr_data_q (wr_data_q),
		.core_wr_data_l (wr_data_l), .core_wr_data_u (wr_data_u),
		.rd_addr_a (core_rd_addr_a), .rd_addr_b (core_rd_addr_b),
		.out_rd_addr (out_rd_addr),
		.rd_data_a (rd_data_a), .rd_data_b (rd_data_b)
	);

	mea_core u_core (
		.clock (clock), .reset (reset), .start (start),
		.no_of_parity (no_of_parity), .no_of_erasures (no_of_erasures),
		.busy (busy), .done (done), .locator_degree (locator_degree),
		.state (state), .core_owns (core_owns),
		.ld_init (ld_init), .ld_init_done (ld_init_done),
		.rd_data_a (rd_data_a), .rd_data_b (rd_data_b),
		.rd_addr_a (core_rd_addr_a), .rd_addr_b (core_rd_addr_b),
		.wr_en (core_wr_en), .wr_addr (core_wr_addr),
		.wr_data_r (wr_data_r), .wr_data_q (wr_data_q),
		.wr_data_l (wr_data_l), .wr_data_u (wr_data_u)
	);

	errata_out u_out (
		.clock (clock), .reset (reset), .start (start),
		.state (state), .send_coefs (send_coefs),
		.rd_addr (out_rd_addr),
		.rd_data_l (rd_data_a[poly_l]), .rd_data_r (rd_data_a[poly_r]),
		.coef_valid (coef_valid), .coef_addr (coef_addr),
		.loc_coef (loc_coef), .mag_coef (mag_coef)
	);

endmodule

/* sim/tb_errata_poly_gen.sv */
`include "rs_defines.svh"

module tb_errata_poly_gen;
	import gf_pkg::*;

	localparam int DEPTH = `RS_POLY_DEPTH;
	localparam int TIMEOUT = 5000; // cycles allowed per wait

	logic clock;
	logic reset;
	logic syndr_wr, erasure_wr, start, send_coefs;
	deg_t syndr_addr, erasure_addr, no_of_parity, no_of_erasures;
	gf_elem_t syndr_coef, erasure_coef;
	logic busy, done, coef_valid;
	deg_t locator_degree, coef_addr;
	gf_elem_t loc_coef, mag_coef;

	int errors;
	int checks;
	bit hung; // DUT stuck busy, later decodes are skipped
	int gf_exp [512];
	int gf_log [256];
	int sym_pos [$]; // erasures first, then errors
	gf_elem_t sym_val [$];
	gf_elem_t synd [DEPTH]; // what the host loads as S(x)
	gf_elem_t eras [DEPTH]; // G(x)
	gf_elem_t exp_l [DEPTH], exp_r [DEPTH];
	gf_elem_t got_l [DEPTH], got_r [DEPTH];
	int exp_deg;

	errata_poly_gen u_dut (
		.clock (clock), .reset (reset),
		.syndr_wr (syndr_wr), .syndr_addr (syndr_addr), .syndr_coef (syndr_coef),
		.erasure_wr (erasure_wr), .erasure_addr (erasure_addr), .erasure_coef (erasure_coef),
		.no_of_parity (no_of_parity), .no_of_erasures (no_of_erasures),
		.start (start), .send_coefs (send_coefs),
		.busy (busy), .done (done), .locator_degree (locator_degree),
		.coef_valid (coef_valid), .coef_addr (coef_addr),
		.loc_coef (loc_coef), .mag_coef (mag_coef)
	);

	initial
	begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	task automatic compare(input string what, input int expected, input int actual);
		checks++;
		if (expected != actual)
		begin
			errors++;
			$display("** Error %s: expected %0h, actual %0h", what, expected, actual);
		end
	endtask

	// log and antilog tables over x^8+x^4+x^3+x^2+1
	task automatic init_tables();
		int v;
		v = 1;
		for (int i = 0; i < 255; i++)
		begin
			gf_exp[i] = v;
			gf_exp[i + 255] = v;
			gf_log[v] = i;
			v = v << 1;
			if (v & 'h100)
				v = v ^ 'h11D;
		end
	endtask

	function automatic gf_elem_t gf_mul(gf_elem_t a, gf_elem_t b);
		if (a == '0 || b == '0)
			return '0;
		return gf_elem_t'(gf_exp[gf_log[a] + gf_log[b]]);
	endfunction

	function automatic gf_elem_t alpha(int n);
		return gf_elem_t'(gf_exp[n % 255]);
	endfunction

	function automatic gf_elem_t poly_eval(gf_elem_t p [DEPTH], gf_elem_t x);
		gf_elem_t acc;
		acc = '0;
		for (int i = DEPTH - 1; i >= 0; i--)
			acc = gf_mul(acc, x) ^ p[i]; // horner
		return acc;
	endfunction

	function automatic int top_degree(gf_elem_t p [DEPTH]);
		for (int i = DEPTH - 1; i > 0; i--)
			if (p[i] != '0)
				return i;
		return 0;
	endfunction

	// reference MEA, L and U degrees are bookkept, R and Q trimmed
	task automatic run_model(input int parity, input int n_eras);
		gf_elem_t r [DEPTH], q [DEPTH], l [DEPTH], u [DEPTH];
		gf_elem_t t [DEPTH], nr [DEPTH], nl [DEPTH];
		gf_elem_t a, b;
		int dr, dq, dl, du, s, tmp;
		for (int i = 0; i < DEPTH; i++)
		begin
			r[i] = '0;
			l[i] = '0;
			q[i] = (i < parity) ? synd[i] : '0;
			if (n_eras == 0)
				u[i] = gf_elem_t'(i == 0);
			else
				u[i] = (i <= n_eras) ? eras[i] : '0;
		end
		r[parity] = 8'h01; // x^parity
		dl = 0;
		du = n_eras;
		for (int iter = 0; iter <= parity; iter++)
		begin
			dr = top_degree(r);
			dq = top_degree(q);
			if (dr < dl || iter == parity)
				break;
			if (dr < dq)
			begin
				t = r;
				r = q;
				q = t;
				t = l;
				l = u;
				u = t;
				tmp = dr;
				dr = dq;
				dq = tmp;
				tmp = dl;
				dl = du;
				du = tmp;
			end
			a = q[dq];
			b = r[dr];
			s = dr - dq;
			for (int i = 0; i < DEPTH; i++)
			begin
				nr[i] = gf_mul(a, r[i]);
				nl[i] = gf_mul(a, l[i]);
				if (i >= s)
				begin
					nr[i] = nr[i] ^ gf_mul(b, q[i - s]);
					nl[i] = nl[i] ^ gf_mul(b, u[i - s]);
				end
			end
			r = nr;
			l = nl;
			if (du + s > dl)
				dl = du + s;
		end
		exp_l = l;
		exp_r = r;
		exp_deg = dl;
	endtask

	task automatic add_random_symbols(input int n);
		int p;
		bit fresh;
		while (n > 0)
		begin
			p = $urandom % 255;
			fresh = 1'b1;
			foreach (sym_pos[k])
				if (sym_pos[k] == p)
					fresh = 1'b0;
			if (fresh)
			begin
				sym_pos.push_back(p);
				sym_val.push_back(gf_elem_t'($urandom_range(1, 255)));
				n--;
			end
		end
	endtask

	// syndromes with first root alpha^1, G(x) and T(x) = S(x)G(x) mod x^parity
	task automatic build_case(input int parity, input int n_eras);
		gf_elem_t s [DEPTH];
		gf_elem_t xp;
		for (int i = 0; i < DEPTH; i++)
		begin
			s[i] = '0;
			eras[i] = '0;
			synd[i] = '0;
		end
		foreach (sym_pos[k])
			for (int j = 0; j < parity; j++)
				s[j] = s[j] ^ gf_mul(sym_val[k], alpha(sym_pos[k] * (j + 1)));
		eras[0] = 8'h01;
		for (int k = 0; k < n_eras; k++)
		begin
			xp = alpha(sym_pos[k]);
			for (int i = DEPTH - 1; i > 0; i--)
				eras[i] = eras[i] ^ gf_mul(xp, eras[i - 1]); // times (1 + X x)
		end
		for (int i = 0; i < parity; i++)
			for (int j = 0; j <= i; j++)
				synd[i] = synd[i] ^ gf_mul(s[i - j], eras[j]);
	endtask

	task automatic decode(input string name, input int parity, input int n_eras, output bit ok);
		int cycles;
		ok = 1'b0;
		if (hung)
			return;
		for (int i = 0; i <= parity; i++)
		begin
			@(posedge clock);
			no_of_parity <= deg_t'(parity);
			no_of_erasures <= deg_t'(n_eras);
			syndr_wr <= (i < parity);
			syndr_addr <= deg_t'(i);
			syndr_coef <= synd[i];
			erasure_wr <= (n_eras != 0) && (i <= n_eras);
			erasure_addr <= deg_t'(i);
			erasure_coef <= eras[i];
		end
		@(posedge clock);
		syndr_wr <= 1'b0;
		erasure_wr <= 1'b0;
		start <= 1'b1;
		@(posedge clock);
		start <= 1'b0;
		@(negedge clock);
		compare({name, " busy after start"}, 1, busy);
		cycles = 0;
		while (!done && cycles < TIMEOUT)
		begin
			@(negedge clock);
			cycles++;
		end
		if (!done)
		begin
			$display("%s: no done pulse within %0d cycles of start", name, TIMEOUT);
			errors++;
			hung = 1'b1;
			return;
		end
		compare({name, " busy at done"}, 0, busy);
		ok = 1'b1;
	endtask

	task automatic read_out(input string name, input bit toggle);
		int n;
		int cycles;
		int issued;
		bit send;
		bit fire_now;
		bit [1:0] in_flight; // requests of one and two cycles ago
		n = 0;
		cycles = 0;
		issued = 0;
		in_flight = '0;
		while (n < DEPTH && cycles < TIMEOUT)
		begin
			@(posedge clock);
			send = toggle ? 1'($urandom_range(0, 1)) : 1'b1;
			send_coefs <= send;
			@(negedge clock);
			cycles++;
			// a coefficient shows up two cycles after its request
			compare($sformatf("%s coef_valid cycle %0d", name, cycles),
				in_flight[1], coef_valid);
			fire_now = send && (issued < DEPTH);
			if (fire_now)
				issued++;
			in_flight = {in_flight[0], fire_now};
			if (coef_valid)
			begin
				compare($sformatf("%s coef_addr #%0d", name, n), n, coef_addr);
				got_l[coef_addr] = loc_coef;
				got_r[coef_addr] = mag_coef;
				n++;
			end
		end
		if (n < DEPTH)
		begin
			$display("%s: readout stopped after %0d of %0d coefficients", name, n, DEPTH);
			errors++;
		end
		for (int i = 0; i < 4; i++)
		begin
			@(posedge clock);
			send_coefs <= 1'b1; // nothing left to send
			@(negedge clock);
			compare({name, " coef_valid after last"}, 0, coef_valid);
		end
		@(posedge clock);
		send_coefs <= 1'b0;
	endtask

	task automatic check_results(input string name, input int parity, input int n_eras);
		run_model(parity, n_eras);
		compare({name, " locator_degree"}, exp_deg, locator_degree);
		for (int i = 0; i < DEPTH; i++)
		begin
			compare($sformatf("%s loc[%0d]", name, i), exp_l[i], got_l[i]);
			compare($sformatf("%s mag[%0d]", name, i), exp_r[i], got_r[i]);
		end
	endtask

	task automatic run_case(input string name, input int parity, input int n_eras,
		input int n_err, input bit toggle);
		bit ok;
		sym_pos.delete();
		sym_val.delete();
		add_random_symbols(n_eras + n_err);
		build_case(parity, n_eras);
		decode(name, parity, n_eras, ok);
		if (!ok)
			return;
		read_out(name, toggle);
		check_results(name, parity, n_eras);
	endtask

	task automatic test_single_error();
		bit ok;
		sym_pos.delete();
		sym_val.delete();
		sym_pos.push_back(37);
		sym_val.push_back(8'h5a);
		build_case(8, 0);
		decode("single_error", 8, 0, ok);
		if (!ok)
			return;
		read_out("single_error", 1'b0);
		check_results("single_error", 8, 0);
		compare("single_error degree", 1, locator_degree);
		// locator vanishes at the inverse of the error location
		compare("single_error root", 0, poly_eval(got_l, alpha(255 - 37)));
	endtask

	task automatic test_second_decode();
		run_case("second_decode", 8, 1, 2, 1'b0); // smaller than the previous decode
		@(negedge clock);
		compare("second_decode busy idle", 0, busy);
	endtask

	initial
	begin
		void'($urandom(96));
		errors = 0;
		checks = 0;
		hung = 1'b0;
		reset = 1'b1;
		syndr_wr = 1'b0;
		syndr_addr = '0;
		syndr_coef = '0;
		erasure_wr = 1'b0;
		erasure_addr = '0;
		erasure_coef = '0;
		no_of_parity = '0;
		no_of_erasures = '0;
		start = 1'b0;
		send_coefs = 1'b0;
		init_tables();
		repeat (9) @(posedge clock);
		@(negedge clock);
		compare("reset busy", 0, busy);
		compare("reset done", 0, done);
		compare("reset coef_valid", 0, coef_valid);
		compare("reset locator_degree", 0, locator_degree);
		@(posedge clock);
		reset <= 1'b0;

		test_single_error();
		run_case("two_errors", 8, 0, 2, 1'b0);
		run_case("erasures_only", 8, 4, 0, 1'b0);
		run_case("errors_and_erasures", 16, 6, 3, 1'b0);
		run_case("readout_pause", 16, 5, 2, 1'b1);
		test_second_decode();

		$display("%0d errors in %0d checks", errors, checks);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

/* flist.f */
+incdir+hw
hw/gf_pkg.sv
hw/mea_pkg.sv
hw/gf_mult.sv
hw/poly_ram.sv
hw/poly_bank.sv
hw/coef_loader.sv
hw/mea_core.sv
hw/errata_out.sv
hw/errata_poly_gen.sv
sim/tb_errata_poly_gen.sv

/* run.sh */
#!/bin/sh
# build and run the errata polynomial generator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_errata_poly_gen -f flist.f -o tb_errata_poly_gen
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_errata_poly_gen > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -q "Regression failed" sim.log; then
	exit 1
fi
exit 0
